/* flist.f */
hdl/rv_core_pkg.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_decoder.sv
hdl/rv_bus_timer.sv
hdl/rv_control_fsm.sv
hdl/rv_datapath.sv
hdl/rv_core_top.sv
testbench/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  # package first, then leaf modules, then the top level
  - hdl/rv_core_pkg.sv
  - hdl/rv_alu.sv
  - hdl/rv_regfile.sv
  - hdl/rv_decoder.sv
  - hdl/rv_bus_timer.sv
  - hdl/rv_control_fsm.sv
  - hdl/rv_datapath.sv
  - hdl/rv_core_top.sv

  - target: simulation
    files:
      - testbench/tb_rv_core.sv

/* testbench/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;

	localparam int          BUS_TIMEOUT = 16;
	localparam logic [31:0] OP_A        = 32'hf000_0123;
	localparam logic [31:0] OP_B        = 32'h0000_0a15;
	// funct12 of one, all register fields zero
	localparam logic [31:0] EBREAK      = {12'h001, 13'd0, rv_core_pkg::OPC_SYSTEM};

	logic                    clock;
	logic                    rst_n_i;
	rv_core_pkg::mem_rsp_t   imem_rsp_i;
	rv_core_pkg::mem_rsp_t   dmem_rsp_i;
	rv_core_pkg::fetch_req_t imem_req_o;
	rv_core_pkg::mem_req_t   dmem_req_o;
	logic                    halted_o;
	logic                    fault_o;

	// word-addressed memory models, 4 KiB each
	logic [31:0] imem [1024];
	logic [31:0] dmem [1024];
	// completed fetches and data writes, plus what the program should produce
	logic [31:0] fetch_log [$];
	logic [31:0] exp_fetch [$];
	logic [31:0] wr_addr [$];
	logic [31:0] wr_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];

	// memory model state
	rv_core_pkg::fetch_req_t i_prev;
	rv_core_pkg::mem_req_t   d_prev;
	int unsigned             i_cnt;
	int unsigned             d_cnt;
	int unsigned             i_delay;
	int unsigned             d_delay;
	bit [31:0]               rng_state = 32'd69574;
	bit                      dmem_stall;
	bit                      dreq_seen;
	int                      stall_cycles;

	// program assembly
	logic [31:0] prog_pc;
	logic [11:0] store_slot;
	logic [31:0] jal_pc;

	string test_name;
	int    test_errs;
	int    hs_errs;
	int    total_errs;
	int    tests_run;
	int    tests_failed;

	rv_core_top i_rv_core_top (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.imem_rsp_i (imem_rsp_i),
		.dmem_rsp_i (dmem_rsp_i),
		.imem_req_o (imem_req_o),
		.dmem_req_o (dmem_req_o),
		.halted_o   (halted_o),
		.fault_o    (fault_o)
	);

	// 40 ns period
	always #20 clock = ~clock;

	function automatic int unsigned lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return {17'd0, rng_state[30:16]};
	endfunction

	// data fill, every word address gets its own value
	function automatic logic [31:0] fill_word(input int idx);
		return 32'h5a5a_0000 ^ (idx * 32'h0001_0003);
	endfunction

	// rv32i instruction formats
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	// sw only
	function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_core_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_core_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, rv_core_pkg::OPC_LUI};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::OPC_JAL};
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
		test_errs++;
		total_errs++;
	endtask

	task automatic report_error(input string msg);
		$display("error in %s: %s", test_name, msg);
		test_errs++;
		total_errs++;
	endtask

	// handshake rule violations, counted apart from the running test
	task automatic report_protocol(input string msg);
		$display("handshake error at %0t: %s", $time, msg);
		hs_errs++;
		total_errs++;
	endtask

	// both ports served from one process so the random delays stay in a fixed order
	always @(negedge clock) begin
		if (!rst_n_i) begin
			imem_rsp_i <= '0;
			dmem_rsp_i <= '0;
			i_prev = '0;
			d_prev = '0;
			i_cnt = 0;
			d_cnt = 0;
			i_delay = lcg_next() % 4;
			d_delay = lcg_next() % 4;
		end else begin
			// fetch port, ready high last negedge means the handshake just completed
			if (imem_rsp_i.ready) begin
				assert (!imem_req_o.valid) else
					report_protocol("fetch valid did not drop after completion");
				imem_rsp_i.ready <= 1'b0;
				i_cnt = 0;
				i_delay = lcg_next() % 4;
			end else begin
				if (i_prev.valid) begin
					assert (fault_o || imem_req_o == i_prev) else
						report_protocol("fetch request changed while waiting for ready");
				end
				if (imem_req_o.valid && i_cnt >= i_delay) begin
					imem_rsp_i.ready <= 1'b1;
					imem_rsp_i.rdata <= imem[imem_req_o.addr[11:2]];
					fetch_log.push_back(imem_req_o.addr);
				end else if (imem_req_o.valid) begin
					i_cnt++;
					stall_cycles++;
				end
			end
			i_prev = imem_req_o;
			// data port, same scheme, writes land when ready goes up
			if (dmem_req_o.valid) begin
				dreq_seen = 1'b1;
			end
			if (dmem_rsp_i.ready) begin
				assert (!dmem_req_o.valid) else
					report_protocol("data valid did not drop after completion");
				dmem_rsp_i.ready <= 1'b0;
				d_cnt = 0;
				d_delay = lcg_next() % 4;
			end else begin
				if (d_prev.valid) begin
					assert (fault_o || dmem_req_o == d_prev) else
						report_protocol("data request changed while waiting for ready");
				end
				if (dmem_req_o.valid && !dmem_stall && d_cnt >= d_delay) begin
					dmem_rsp_i.ready <= 1'b1;
					if (dmem_req_o.we) begin
						dmem[dmem_req_o.addr[11:2]] = dmem_req_o.wdata;
						wr_addr.push_back(dmem_req_o.addr);
						wr_data.push_back(dmem_req_o.wdata);
					end else begin
						dmem_rsp_i.rdata <= dmem[dmem_req_o.addr[11:2]];
					end
				end else if (dmem_req_o.valid) begin
					d_cnt++;
					stall_cycles++;
				end
			end
			d_prev = dmem_req_o;
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d error(s)", test_name, test_errs);
			tests_failed++;
		end
	endtask

	// reset goes low here, memories reload one cycle later when the models are idle
	task automatic begin_program(input string name);
		start_test(name);
		@(negedge clock);
		rst_n_i <= 1'b0;
		@(negedge clock);
		for (int i = 0; i < 1024; i++) begin
			imem[i] = '0;
			dmem[i] = fill_word(i);
		end
		fetch_log.delete();
		exp_fetch.delete();
		wr_addr.delete();
		wr_data.delete();
		exp_addr.delete();
		exp_data.delete();
		dmem_stall = 1'b0;
		dreq_seen = 1'b0;
		prog_pc = '0;
		store_slot = 12'h400;
	endtask

	// 16 cycles of reset in total, then the state right after release
	task automatic release_reset();
		repeat (15) @(negedge clock);
		rst_n_i <= 1'b1;
		@(negedge clock);
		assert (imem_req_o.valid) else report_error("no fetch request after reset");
		assert (imem_req_o.addr == 32'h0) else
			report_mismatch("first fetch address", 32'h0, imem_req_o.addr);
		assert (!dmem_req_o.valid && !halted_o && !fault_o) else
			report_error("data valid or status high after reset");
	endtask

	// instruction on the executed path
	task automatic emit(input logic [31:0] word);
		imem[prog_pc[11:2]] = word;
		exp_fetch.push_back(prog_pc);
		prog_pc += 32'd4;
	endtask

	// instruction that a taken branch or jump must pass over
	task automatic emit_skipped(input logic [31:0] word);
		imem[prog_pc[11:2]] = word;
		prog_pc += 32'd4;
	endtask

	task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// lui plus addi, upper part rounded so the sign-extended low part adds back
	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] rounded;
		rounded = value + 32'h800;
		emit(u_type(rounded[31:12], rd));
		emit(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, rd, rd, value[11:0]));
	endtask

	// result goes to x3 and is stored to the next slot
	task automatic alu_case(input logic [31:0] word, input logic [31:0] expected);
		emit(word);
		emit(s_type(5'd3, 5'd0, store_slot));
		expect_write({20'd0, store_slot}, expected);
		store_slot += 12'd4;
	endtask

	// lw, add one, sw back, base in x10
	task automatic reload_increment(input logic [4:0] rd, input logic [11:0] load_off,
		input logic [11:0] store_off, input logic [31:0] loaded);
		emit(i_type(rv_core_pkg::OPC_LOAD, 3'b010, rd, 5'd10, load_off));
		emit(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, rd, rd, 12'h001));
		emit(s_type(rd, 5'd10, store_off));
		expect_write(32'h500 + store_off, loaded + 32'd1);
	endtask

	task automatic wait_for_end(input int max_cycles);
		int n;
		n = 0;
		while (!halted_o && !fault_o && n < max_cycles) begin
			@(negedge clock);
			n++;
		end
		assert (halted_o || fault_o) else
			report_error("timeout, core neither halted nor faulted");
	endtask

	task automatic check_writes();
		int n;
		n = (wr_addr.size() < exp_addr.size()) ? wr_addr.size() : exp_addr.size();
		assert (wr_addr.size() == exp_addr.size()) else
			report_mismatch("data write count", exp_addr.size(), wr_addr.size());
		for (int i = 0; i < n; i++) begin
			assert (wr_addr[i] == exp_addr[i]) else
				report_mismatch("data write address", exp_addr[i], wr_addr[i]);
			assert (wr_data[i] == exp_data[i]) else
				report_mismatch("data write value", exp_data[i], wr_data[i]);
		end
	endtask

	task automatic check_fetches();
		int n;
		n = (fetch_log.size() < exp_fetch.size()) ? fetch_log.size() : exp_fetch.size();
		assert (fetch_log.size() == exp_fetch.size()) else
			report_mismatch("fetch count", exp_fetch.size(), fetch_log.size());
		for (int i = 0; i < n; i++) begin
			assert (fetch_log[i] == exp_fetch[i]) else
				report_mismatch("fetch address", exp_fetch[i], fetch_log[i]);
		end
	endtask

	task automatic run_and_check();
		release_reset();
		wait_for_end(3000);
		assert (halted_o && !fault_o) else report_error("program did not end in halt");
		check_writes();
		check_fetches();
	endtask

	initial begin
		int n;
		int n_fetch;
		clock = 1'b0;
		// reset falls on the first negedge so every flop sees a clean edge
		rst_n_i = 1'b1;
		imem_rsp_i = '0;
		dmem_rsp_i = '0;
		hs_errs = 0;
		total_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		stall_cycles = 0;

		// every kept alu and immediate operation on x1 = OP_A, x2 = OP_B
		begin_program("arithmetic");
		load_const(5'd1, OP_A);
		load_const(5'd2, OP_B);
		alu_case(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), OP_A + OP_B);
		alu_case(r_type(7'h20, 3'b000, 5'd3, 5'd1, 5'd2), OP_A - OP_B);
		alu_case(r_type(7'h00, 3'b111, 5'd3, 5'd1, 5'd2), OP_A & OP_B);
		alu_case(r_type(7'h00, 3'b110, 5'd3, 5'd1, 5'd2), OP_A | OP_B);
		alu_case(r_type(7'h00, 3'b100, 5'd3, 5'd1, 5'd2), OP_A ^ OP_B);
		alu_case(r_type(7'h00, 3'b010, 5'd3, 5'd1, 5'd2), 32'($signed(OP_A) < $signed(OP_B)));
		alu_case(r_type(7'h00, 3'b010, 5'd3, 5'd2, 5'd1), 32'($signed(OP_B) < $signed(OP_A)));
		alu_case(r_type(7'h00, 3'b001, 5'd3, 5'd1, 5'd2), OP_A << OP_B[4:0]);
		alu_case(r_type(7'h00, 3'b101, 5'd3, 5'd1, 5'd2), OP_A >> OP_B[4:0]);
		// immediates sign-extended by hand
		alu_case(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd1, 12'hffb), OP_A - 32'd5);
		alu_case(i_type(rv_core_pkg::OPC_OP_IMM, 3'b111, 5'd3, 5'd1, 12'h7f0), OP_A & 32'h7f0);
		alu_case(i_type(rv_core_pkg::OPC_OP_IMM, 3'b110, 5'd3, 5'd1, 12'h8f0),
			OP_A | 32'hffff_f8f0);
		alu_case(i_type(rv_core_pkg::OPC_OP_IMM, 3'b100, 5'd3, 5'd1, 12'h555), OP_A ^ 32'h555);
		alu_case(i_type(rv_core_pkg::OPC_OP_IMM, 3'b010, 5'd3, 5'd1, 12'hfff),
			32'($signed(OP_A) < -1));
		alu_case(i_type(rv_core_pkg::OPC_OP_IMM, 3'b010, 5'd3, 5'd2, 12'h7ff),
			32'($signed(OP_B) < 2047));
		alu_case(u_type(20'habcde, 5'd3), 32'habcd_e000);
		emit(EBREAK);
		run_and_check();
		finish_test();

		// store, reload, increment, store again
		begin_program("load_store");
		emit(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd10, 5'd0, 12'h500));
		load_const(5'd5, 32'h1234_5678);
		emit(s_type(5'd5, 5'd10, 12'h000));
		expect_write(32'h500, 32'h1234_5678);
		load_const(5'd6, 32'hffff_ffff);
		emit(s_type(5'd6, 5'd10, 12'h004));
		expect_write(32'h504, 32'hffff_ffff);
		reload_increment(5'd7, 12'h000, 12'h010, 32'h1234_5678);
		reload_increment(5'd8, 12'h004, 12'h014, 32'hffff_ffff);
		// never written, loads the fill value
		reload_increment(5'd9, 12'h100, 12'h018, fill_word(32'h600 >> 2));
		// x0 keeps zero
		emit(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'd77));
		emit(s_type(5'd0, 5'd10, 12'h01c));
		expect_write(32'h51c, 32'h0);
		emit(EBREAK);
		run_and_check();
		finish_test();

		// taken and not-taken branches, jal, x4 only changes on a skipped slot
		begin_program("control_flow");
		emit(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5));
		emit(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'd5));
		emit(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd7));
		emit(b_type(3'b000, 5'd1, 5'd2, 13'd8));
		emit_skipped(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd4, 5'd0, 12'd1));
		emit(b_type(3'b001, 5'd1, 5'd2, 13'd8));
		emit(b_type(3'b001, 5'd1, 5'd3, 13'd8));
		emit_skipped(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd4, 5'd0, 12'd2));
		emit(b_type(3'b000, 5'd1, 5'd3, 13'd8));
		jal_pc = prog_pc;
		emit(j_type(5'd5, 21'd12));
		emit_skipped(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd4, 5'd0, 12'd3));
		emit_skipped(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd4, 5'd0, 12'd4));
		emit(s_type(5'd5, 5'd0, 12'h700));
		expect_write(32'h700, jal_pc + 32'd4);
		emit(s_type(5'd4, 5'd0, 12'h704));
		expect_write(32'h704, 32'h0);
		emit(EBREAK);
		run_and_check();
		finish_test();

		// core stays halted, no new fetch
		start_test("halt");
		assert (halted_o && !fault_o) else report_error("core not halted after ebreak");
		n_fetch = fetch_log.size();
		repeat (20) begin
			@(negedge clock);
			assert (!imem_req_o.valid && halted_o) else
				report_error("fetch request or halt drop after ebreak");
		end
		assert (fetch_log.size() == n_fetch) else
			report_mismatch("fetch count after halt", n_fetch, fetch_log.size());
		finish_test();

		// load to a data memory that never answers
		begin_program("timeout_fault");
		dmem_stall = 1'b1;
		emit(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'h040));
		emit(i_type(rv_core_pkg::OPC_LOAD, 3'b010, 5'd2, 5'd1, 12'h000));
		emit_skipped(EBREAK);
		release_reset();
		n = 0;
		while (!dmem_req_o.valid && n < 200) begin
			@(negedge clock);
			n++;
		end
		assert (dmem_req_o.valid) else report_error("timeout, stalled load never requested");
		// count from the first cycle of valid
		n = 0;
		while (!fault_o && n < 4 * BUS_TIMEOUT) begin
			@(negedge clock);
			n++;
		end
		assert (fault_o) else report_error("timeout, fault_o never rose");
		assert (n == BUS_TIMEOUT) else
			report_mismatch("cycles from valid to fault", BUS_TIMEOUT, n);
		repeat (10) begin
			assert (!dmem_req_o.valid && !imem_req_o.valid && fault_o) else
				report_error("request valid or fault drop after the fault");
			@(negedge clock);
		end
		check_fetches();
		finish_test();

		// undefined opcode 7'b1111111 right after a valid instruction
		begin_program("illegal_fault");
		emit(i_type(rv_core_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd1));
		emit(32'h0000_007f);
		emit_skipped(s_type(5'd1, 5'd0, 12'h040));
		release_reset();
		wait_for_end(500);
		assert (fault_o && !halted_o) else report_error("undefined opcode did not fault");
		assert (!dreq_seen) else report_error("data request issued before the fault");
		check_fetches();
		finish_test();

		// stability and drop checks ran in the memory models the whole time
		start_test("handshake");
		assert (stall_cycles > 0) else report_error("no request ever waited for ready");
		test_errs = test_errs + hs_errs;
		finish_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			total_errs);
		if (total_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* hdl/rv_core_top.sv */
`timescale 1ns/100ps

module rv_core_top #(
	parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC    = '0,
	parameter int                           BUS_TIMEOUT = 16
) (
	input  logic                    clock,
	input  logic                    rst_n_i,
	input  rv_core_pkg::mem_rsp_t   imem_rsp_i,
	input  rv_core_pkg::mem_rsp_t   dmem_rsp_i,
	output rv_core_pkg::fetch_req_t imem_req_o,
	output rv_core_pkg::mem_req_t   dmem_req_o,
	output logic                    halted_o,
	output logic                    fault_o
);

	// sequencing enables
	logic fetch_en;
	logic exec_en;
	logic mem_en;
	logic load_wb_en;
	// handshake completion
	logic fetch_done;
	logic mem_done;
	// bus watchdog
	logic waiting;
	logic timeout;

	logic [rv_core_pkg::XLEN-1:0] instr;
	rv_core_pkg::decode_t         dec;

	rv_control_fsm u_rv_control_fsm (
		.clock        (clock),
		.rst_n_i      (rst_n_i),
		.dec_i        (dec),
		.fetch_done_i (fetch_done),
		.mem_done_i   (mem_done),
		.timeout_i    (timeout),
		.fetch_en_o   (fetch_en),
		.exec_en_o    (exec_en),
		.mem_en_o     (mem_en),
		.load_wb_en_o (load_wb_en),
		.waiting_o    (waiting),
		.halted_o     (halted_o),
		.fault_o      (fault_o)
	);

	rv_bus_timer #(
		.BUS_TIMEOUT (BUS_TIMEOUT)
	) u_rv_bus_timer (
		.clock     (clock),
		.rst_n_i   (rst_n_i),
		.waiting_i (waiting),
		.timeout_o (timeout)
	);

	rv_decoder u_rv_decoder (
		.instr_i (instr),
		.dec_o   (dec)
	);

	rv_datapath #(
		.RESET_PC (RESET_PC)
	) u_rv_datapath (
		.clock        (clock),
		.rst_n_i      (rst_n_i),
		.dec_i        (dec),
		.fetch_en_i   (fetch_en),
		.exec_en_i    (exec_en),
		.mem_en_i     (mem_en),
		.load_wb_en_i (load_wb_en),
		.imem_rsp_i   (imem_rsp_i),
		.dmem_rsp_i   (dmem_rsp_i),
		.instr_o      (instr),
		.fetch_done_o (fetch_done),
		.mem_done_o   (mem_done),
		.imem_req_o   (imem_req_o),
		.dmem_req_o   (dmem_req_o)
	);

endmodule

/* hdl/rv_datapath.sv */
`timescale 1ns/100ps

module rv_datapath #(
	parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                         clock,
	input  logic                         rst_n_i,
	input  rv_core_pkg::decode_t         dec_i,
	input  logic                         fetch_en_i,
	input  logic                         exec_en_i,
	input  logic                         mem_en_i,
	input  logic                         load_wb_en_i,
	input  rv_core_pkg::mem_rsp_t        imem_rsp_i,
	input  rv_core_pkg::mem_rsp_t        dmem_rsp_i,
	output logic [rv_core_pkg::XLEN-1:0] instr_o,
	output logic                         fetch_done_o,
	output logic                         mem_done_o,
	output rv_core_pkg::fetch_req_t      imem_req_o,
	output rv_core_pkg::mem_req_t        dmem_req_o
);

	logic [rv_core_pkg::XLEN-1:0] pc_q;
	logic [rv_core_pkg::XLEN-1:0] instr_q;
	logic [rv_core_pkg::XLEN-1:0] mem_addr_q;
	logic [rv_core_pkg::XLEN-1:0] mem_wdata_q;
	logic [rv_core_pkg::XLEN-1:0] rs1_data;
	logic [rv_core_pkg::XLEN-1:0] rs2_data;
	logic [rv_core_pkg::XLEN-1:0] alu_b;
	logic [rv_core_pkg::XLEN-1:0] alu_y;
	logic [rv_core_pkg::XLEN-1:0] pc_plus4;
	logic [rv_core_pkg::XLEN-1:0] pc_next;
	logic [rv_core_pkg::XLEN-1:0] rf_wdata;
	logic                         rf_we;
	logic                         branch_taken;

	// pc moves only at the end of execute
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= RESET_PC;
		end else if (exec_en_i) begin
			pc_q <= pc_next;
		end
	end

	// fetched word taken with ready
	always_ff @(posedge clock) begin
		if (fetch_en_i && imem_rsp_i.ready) begin
			instr_q <= imem_rsp_i.rdata;
		end
	end

	// data request fields, held stable through mem
	always_ff @(posedge clock) begin
		if (exec_en_i) begin
			mem_addr_q  <= alu_y;
			mem_wdata_q <= rs2_data;
		end
	end

	rv_regfile u_rv_regfile (
		.clock    (clock),
		.rst_n_i  (rst_n_i),
		.we_i     (rf_we),
		.waddr_i  (dec_i.rd),
		.wdata_i  (rf_wdata),
		.raddr1_i (dec_i.rs1),
		.raddr2_i (dec_i.rs2),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	// operand b is imm or rs2
	assign alu_b = dec_i.use_imm ? dec_i.imm : rs2_data;

	rv_alu u_rv_alu (
		.op_i (dec_i.alu_op),
		.a_i  (rs1_data),
		.b_i  (alu_b),
		.y_o  (alu_y)
	);

	// branch compares through sub, zero means equal
	assign branch_taken = dec_i.is_branch && ((alu_y == '0) ^ dec_i.branch_ne);

	assign pc_plus4 = pc_q + 32'd4;
	// both jal and branch targets are pc relative
	assign pc_next  = (dec_i.is_jal || branch_taken) ? pc_q + dec_i.imm : pc_plus4;

	// execute writes alu or link, mem writes load data
	assign rf_we    = (exec_en_i && dec_i.reg_write) || load_wb_en_i;
	assign rf_wdata = load_wb_en_i ? dmem_rsp_i.rdata :
		(dec_i.is_jal ? pc_plus4 : alu_y);

	assign imem_req_o.valid = fetch_en_i;
	assign imem_req_o.addr  = pc_q;
	assign fetch_done_o     = imem_rsp_i.ready;

	assign dmem_req_o.valid = mem_en_i;
	// decode stays valid in mem, instr_q is untouched until the next fetch
	assign dmem_req_o.we    = dec_i.is_store;
	assign dmem_req_o.addr  = mem_addr_q;
	assign dmem_req_o.wdata = mem_wdata_q;
	assign mem_done_o       = dmem_rsp_i.ready;

	assign instr_o = instr_q;

endmodule

/* hdl/rv_control_fsm.sv */
`timescale 1ns/100ps

module rv_control_fsm (
	input  logic                 clock,
	input  logic                 rst_n_i,
	input  rv_core_pkg::decode_t dec_i,
	input  logic                 fetch_done_i,
	input  logic                 mem_done_i,
	input  logic                 timeout_i,
	output logic                 fetch_en_o,
	output logic                 exec_en_o,
	output logic                 mem_en_o,
	output logic                 load_wb_en_o,
	output logic                 waiting_o,
	output logic                 halted_o,
	output logic                 fault_o
);

	rv_core_pkg::core_state_e state_q;
	rv_core_pkg::core_state_e state_d;

	// state register, reset lands straight in fetch
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= rv_core_pkg::ST_FETCH;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			rv_core_pkg::ST_FETCH: begin
				// stuck bus wins over a late answer
				if (timeout_i) begin
					state_d = rv_core_pkg::ST_FAULT;
				end else if (fetch_done_i) begin
					state_d = rv_core_pkg::ST_EXECUTE;
				end
			end
			rv_core_pkg::ST_EXECUTE: begin
				// single cycle, decide where the instruction goes next
				if (dec_i.illegal) begin
					state_d = rv_core_pkg::ST_FAULT;
				end else if (dec_i.is_ebreak) begin
					state_d = rv_core_pkg::ST_HALT;
				end else if (dec_i.is_load || dec_i.is_store) begin
					state_d = rv_core_pkg::ST_MEM;
				end else begin
					state_d = rv_core_pkg::ST_FETCH;
				end
			end
			rv_core_pkg::ST_MEM: begin
				if (timeout_i) begin
					state_d = rv_core_pkg::ST_FAULT;
				end else if (mem_done_i) begin
					state_d = rv_core_pkg::ST_FETCH;
				end
			end
			// halt and fault hold until reset
			default: begin
				state_d = state_q;
			end
		endcase
	end

	// enables straight from the state
	assign fetch_en_o = (state_q == rv_core_pkg::ST_FETCH);
	assign exec_en_o  = (state_q == rv_core_pkg::ST_EXECUTE);
	assign mem_en_o   = (state_q == rv_core_pkg::ST_MEM);

	// load data written back in the completing cycle
	assign load_wb_en_o = mem_en_o && mem_done_i && dec_i.is_load;

	// outstanding request not answered this cycle
	// low on completion so the timer restarts for the next request
	assign waiting_o = (fetch_en_o && !fetch_done_i) || (mem_en_o && !mem_done_i);

	assign halted_o = (state_q == rv_core_pkg::ST_HALT);
	assign fault_o  = (state_q == rv_core_pkg::ST_FAULT);

endmodule

/* hdl/rv_bus_timer.sv */
`timescale 1ns/100ps

module rv_bus_timer #(
	parameter int BUS_TIMEOUT = 16
) (
	input  logic clock,
	input  logic rst_n_i,
	input  logic waiting_i,
	output logic timeout_o
);

	// wide enough to hold BUS_TIMEOUT - 1
	localparam int CNT_W = $clog2(BUS_TIMEOUT + 1);

	logic [CNT_W-1:0] wait_cnt_q;

	// counts consecutive unanswered cycles
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wait_cnt_q <= '0;
		end else if (!waiting_i) begin
			wait_cnt_q <= '0;
		end else begin
			wait_cnt_q <= wait_cnt_q + 1'b1;
		end
	end

	// fires in the last allowed wait cycle, fsm faults on the next edge
	assign timeout_o = waiting_i && (wait_cnt_q == CNT_W'(BUS_TIMEOUT - 1));

endmodule

/* hdl/rv_decoder.sv */
`timescale 1ns/100ps

module rv_decoder (
	input  logic [rv_core_pkg::XLEN-1:0] instr_i,
	output rv_core_pkg::decode_t         dec_o
);

	logic [6:0]                   opcode;
	logic [2:0]                   funct3;
	logic [6:0]                   funct7;
	logic [rv_core_pkg::XLEN-1:0] imm_i_type;
	logic [rv_core_pkg::XLEN-1:0] imm_s_type;
	logic [rv_core_pkg::XLEN-1:0] imm_b_type;
	logic [rv_core_pkg::XLEN-1:0] imm_u_type;
	logic [rv_core_pkg::XLEN-1:0] imm_j_type;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// sign extended immediates, one per format
	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'b0};
	assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb begin
		dec_o        = '0;
		dec_o.alu_op = rv_core_pkg::ALU_ADD;
		// register fields sit at fixed positions
		dec_o.rd     = instr_i[11:7];
		dec_o.rs1    = instr_i[19:15];
		dec_o.rs2    = instr_i[24:20];
		case (opcode)
			rv_core_pkg::OPC_OP: begin
				dec_o.reg_write = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'b000}: dec_o.alu_op = rv_core_pkg::ALU_ADD;
					{7'h20, 3'b000}: dec_o.alu_op = rv_core_pkg::ALU_SUB;
					{7'h00, 3'b111}: dec_o.alu_op = rv_core_pkg::ALU_AND;
					{7'h00, 3'b110}: dec_o.alu_op = rv_core_pkg::ALU_OR;
					{7'h00, 3'b100}: dec_o.alu_op = rv_core_pkg::ALU_XOR;
					{7'h00, 3'b010}: dec_o.alu_op = rv_core_pkg::ALU_SLT;
					{7'h00, 3'b001}: dec_o.alu_op = rv_core_pkg::ALU_SLL;
					{7'h00, 3'b101}: dec_o.alu_op = rv_core_pkg::ALU_SRL;
					default: begin
						dec_o.reg_write = 1'b0;
						dec_o.illegal   = 1'b1;
					end
				endcase
			end
			rv_core_pkg::OPC_OP_IMM: begin
				dec_o.use_imm   = 1'b1;
				dec_o.reg_write = 1'b1;
				dec_o.imm       = imm_i_type;
				// immediate shifts are outside the subset
				case (funct3)
					3'b000: dec_o.alu_op = rv_core_pkg::ALU_ADD;
					3'b111: dec_o.alu_op = rv_core_pkg::ALU_AND;
					3'b110: dec_o.alu_op = rv_core_pkg::ALU_OR;
					3'b100: dec_o.alu_op = rv_core_pkg::ALU_XOR;
					3'b010: dec_o.alu_op = rv_core_pkg::ALU_SLT;
					default: begin
						dec_o.reg_write = 1'b0;
						dec_o.illegal   = 1'b1;
					end
				endcase
			end
			rv_core_pkg::OPC_LUI: begin
				dec_o.alu_op    = rv_core_pkg::ALU_PASS_B;
				dec_o.use_imm   = 1'b1;
				dec_o.reg_write = 1'b1;
				dec_o.imm       = imm_u_type;
			end
			rv_core_pkg::OPC_LOAD: begin
				// word only, address is rs1 + imm
				dec_o.use_imm = 1'b1;
				dec_o.imm     = imm_i_type;
				dec_o.is_load = (funct3 == 3'b010);
				dec_o.illegal = (funct3 != 3'b010);
			end
			rv_core_pkg::OPC_STORE: begin
				dec_o.use_imm  = 1'b1;
				dec_o.imm      = imm_s_type;
				dec_o.is_store = (funct3 == 3'b010);
				dec_o.illegal  = (funct3 != 3'b010);
			end
			rv_core_pkg::OPC_BRANCH: begin
				// equality via rs1 - rs2 in the alu
				dec_o.alu_op    = rv_core_pkg::ALU_SUB;
				dec_o.imm       = imm_b_type;
				dec_o.is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
				dec_o.branch_ne = (funct3 == 3'b001);
				dec_o.illegal   = !dec_o.is_branch;
			end
			rv_core_pkg::OPC_JAL: begin
				dec_o.reg_write = 1'b1;
				dec_o.is_jal    = 1'b1;
				dec_o.imm       = imm_j_type;
			end
			rv_core_pkg::OPC_SYSTEM: begin
				// ebreak is the only system instruction kept
				dec_o.is_ebreak = (instr_i == 32'h0010_0073);
				dec_o.illegal   = (instr_i != 32'h0010_0073);
			end
			default: begin
				dec_o.illegal = 1'b1;
			end
		endcase
	end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
	input  logic                               clock,
	input  logic                               rst_n_i,
	input  logic                               we_i,
	input  logic [rv_core_pkg::REG_ADDR_W-1:0] waddr_i,
	input  logic [rv_core_pkg::XLEN-1:0]       wdata_i,
	input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr1_i,
	input  logic [rv_core_pkg::REG_ADDR_W-1:0] raddr2_i,
	output logic [rv_core_pkg::XLEN-1:0]       rdata1_o,
	output logic [rv_core_pkg::XLEN-1:0]       rdata2_o
);

	logic [rv_core_pkg::XLEN-1:0] regs_q [2**rv_core_pkg::REG_ADDR_W];

	// single write port, x0 never written
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 2**rv_core_pkg::REG_ADDR_W; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// asynchronous reads, x0 forced to zero
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
	input  rv_core_pkg::alu_op_e         op_i,
	input  logic [rv_core_pkg::XLEN-1:0] a_i,
	input  logic [rv_core_pkg::XLEN-1:0] b_i,
	output logic [rv_core_pkg::XLEN-1:0] y_o
);

	// shift amount from the low five bits
	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb begin
		case (op_i)
			rv_core_pkg::ALU_ADD:    y_o = a_i + b_i;
			rv_core_pkg::ALU_SUB:    y_o = a_i - b_i;
			rv_core_pkg::ALU_AND:    y_o = a_i & b_i;
			rv_core_pkg::ALU_OR:     y_o = a_i | b_i;
			rv_core_pkg::ALU_XOR:    y_o = a_i ^ b_i;
			// signed compare, result is 0 or 1
			rv_core_pkg::ALU_SLT:    y_o = {{(rv_core_pkg::XLEN-1){1'b0}},
				($signed(a_i) < $signed(b_i))};
			rv_core_pkg::ALU_SLL:    y_o = a_i << shamt;
			rv_core_pkg::ALU_SRL:    y_o = a_i >> shamt;
			// lui passes the upper immediate through
			rv_core_pkg::ALU_PASS_B: y_o = b_i;
			default:                 y_o = '0;
		endcase
	end

endmodule

/* hdl/rv_core_pkg.sv */
package rv_core_pkg;

	// data and address width
	localparam int XLEN       = 32;
	// register index width
	localparam int REG_ADDR_W = 5;

	// major opcodes of the kept subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// alu operations
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

	// instruction sequencing states
	typedef enum logic [2:0] {
		ST_FETCH,
		ST_EXECUTE,
		ST_MEM,
		ST_HALT,
		ST_FAULT
	} core_state_e;

	// decoded instruction
	typedef struct packed {
		alu_op_e               alu_op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [XLEN-1:0]       imm;
		// operand b from imm instead of rs2
		logic                  use_imm;
		// rd written at the end of execute
		logic                  reg_write;
		logic                  is_load;
		logic                  is_store;
		logic                  is_branch;
		// bne when set, beq otherwise
		logic                  branch_ne;
		logic                  is_jal;
		logic                  is_ebreak;
		logic                  illegal;
	} decode_t;

	// fetch port request
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] addr;
	} fetch_req_t;

	// data port request
	typedef struct packed {
		logic            valid;
		logic            we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} mem_req_t;

	// response, shared by both ports
	typedef struct packed {
		logic            ready;
		logic [XLEN-1:0] rdata;
	} mem_rsp_t;

endpackage
